// ==== tb.f ====
wexDecPkg.sv
opSlotDecoder.sv
bundleSteer.sv
dualLanePair.sv
wexDecodeTop.sv
tb_wexDecode_properties.sv
tb_wexDecode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_wexDecode
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_wexDecode.sv ====
`timescale 1ns/1ps

module tb_wexDecode;

	import wexDecPkg::*;

	localparam int NumDirected = 14;
	localparam int NumRandom   = 400;
	localparam int NumWords    = NumDirected + NumRandom;

	logic        clock = 1'b0;
	logic        arstN;
	logic        inValid;
	logic [95:0] istrWord;
	logic        srWxe;
	logic        outValid;
	laneOp_t     laneA;
	laneOp_t     laneB;
	laneOp_t     laneC;
	integer      seed;

	wexDecodeTop dut (.*);

	bind wexDecodeTop tb_wexDecode_properties props (.*);

	always #4 clock = ~clock;

	// regs is rn, rm, ro from high to low
	function automatic logic [31:0] makeOp(input logic [3:0] prefix, input logic [1:0] wexBits,
		input logic pwex, input logic [5:0] uCmd, input logic [17:0] regs);
		return {regs[11:6], regs[5:0], uCmd[3:0], prefix, wexBits, pwex, 1'b0,
			regs[17:12], uCmd[5:4]};
	endfunction

	function automatic logic [31:0] makeJumbo(input logic [24:0] p);
		return {p[15:0], 7'h7F, p[24:16]};
	endfunction

	task automatic applyWord(input logic [95:0] w, input logic wxe, input logic v);
		@(posedge clock);
		#1;
		istrWord = w;
		srWxe    = wxe;
		inValid  = v;
	endtask

	task automatic failRun(input string why);
		$display("Testbench failed");
		$fatal(1, "%s", why);
	endtask

	task automatic runDirected();
		logic [31:0] fxWex;
		logic [31:0] fxPlain;
		fxWex   = makeOp(4'hF, 2'b01, 1'b0, 6'h05, 18'o123456);
		fxPlain = makeOp(4'hF, 2'b00, 1'b0, 6'h12, 18'o654321);
		// scalar, non-Fx then Fx
		applyWord({32'h0, 32'h0, makeOp(4'h3, 2'b11, 1'b1, 6'h07, 18'o010203)}, 1'b1, 1'b1);
		applyWord({32'h0, fxWex, fxPlain}, 1'b1, 1'b1);
		// WEX2, then the same word with WEX off
		applyWord({32'h0, fxPlain, fxWex}, 1'b1, 1'b1);
		applyWord({32'h0, fxPlain, fxWex}, 1'b0, 1'b1);
		// WEX3 both ways, then a gap
		applyWord({fxPlain, fxWex, fxWex}, 1'b1, 1'b1);
		applyWord({fxPlain, fxWex, fxWex}, 1'b0, 1'b1);
		applyWord('0, 1'b1, 1'b0);
		// predicated op chains only with pwex
		applyWord({32'h0, fxPlain, makeOp(4'hE, 2'b10, 1'b1, 6'h21, 18'o332211)}, 1'b1, 1'b1);
		applyWord({32'h0, fxPlain, makeOp(4'hE, 2'b10, 1'b0, 6'h21, 18'o332211)}, 1'b1, 1'b1);
		// jumbo, positive and negative payload
		applyWord({32'h0, fxPlain, makeJumbo(25'h0ABCDEF)}, 1'b0, 1'b1);
		applyWord({32'h0, fxPlain, makeJumbo(25'h1F00F00)}, 1'b0, 1'b1);
		// dual-lane, ALU class then move class
		applyWord({32'h0, 32'h0, makeOp(4'hF, 2'b00, 1'b0, 6'h30, 18'o172737)}, 1'b0, 1'b1);
		applyWord({32'h0, 32'h0, makeOp(4'hF, 2'b00, 1'b0, 6'h34, 18'o172737)}, 1'b0, 1'b1);
		// dual op inside WEX2 moves slot 0 to lane C
		applyWord({32'h0, makeOp(4'hF, 2'b00, 1'b0, 6'h38, 18'o453627), fxWex}, 1'b1, 1'b1);
	endtask

	// biased toward Fx prefixes, WEX bits, dual-lane uCmd and jumbo marks
	task automatic randomSlot(output logic [31:0] s);
		logic [31:0] bias;
		s    = $random(seed);
		bias = $random(seed);
		if (bias[1:0] != 2'b00)
			s[15:12] = bias[2] ? 4'hF : 4'hE;
		if (bias[3])
			s[10] = 1'b1;
		if (bias[4])
			s[11:9] = 3'b111;
		if (bias[5])
			s[1:0] = 2'b11;
		if (bias[9:7] == 3'b000)
			s[15:9] = 7'h7F;
	endtask

	task automatic runRandom();
		logic [31:0] s0;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] ctl;
		for (int i = 0; i < NumRandom; i++)
		begin
			randomSlot(s0);
			randomSlot(s1);
			randomSlot(s2);
			ctl = $random(seed);
			// roughly one gap in eight
			applyWord({s2, s1, s0}, ctl[0], ctl[3:1] != 3'b000);
		end
	endtask

	always @(negedge clock)
	begin
		if (dut.props.failCount != 0)
			failRun("a decoder assertion failed");
	end

	initial
	begin
		#((NumWords + 50) * 8);
		failRun("timeout, the stimulus did not finish in time");
	end

	initial
	begin
		seed     = 32'h4b95_0dfe;
		arstN    = 1'b0;
		inValid  = 1'b0;
		istrWord = '0;
		srWxe    = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		arstN = 1'b1;
		runDirected();
		runRandom();
		applyWord('0, 1'b0, 1'b0);
		repeat (2) @(posedge clock);
		#2;
		if (dut.props.failCount == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
			failRun("decoder assertions failed");
	end

endmodule

// ==== tb_wexDecode_properties.sv ====
`timescale 1ns/1ps

module tb_wexDecode_properties (
	input logic                          clock,
	input logic                          arstN,
	input logic                          inValid,
	input logic [3*wexDecPkg::SlotW-1:0] istrWord,
	input logic                          srWxe,
	input logic                          outValid,
	input wexDecPkg::laneOp_t            laneA,
	input wexDecPkg::laneOp_t            laneB,
	input wexDecPkg::laneOp_t            laneC
);

	import wexDecPkg::*;

	typedef enum logic [1:0] {FormScalar, FormWex2, FormWex3, FormJumbo} form_t;

	typedef struct packed {
		laneOp_t a;
		laneOp_t b;
		laneOp_t c;
		form_t   form;
		logic    dual;
	} expect_t;

	// count of failed checks
	int failCount = 0;

	expect_t            expNow;
	logic [3*57-1:0]    lanesExp;
	logic [3*57-1:0]    lanesNow;

	// fields of one slot as laid out in the op view
	function automatic laneOp_t opOf(input logic [31:0] s);
		laneOp_t o;
		o.rn   = s[7:2];
		o.rm   = s[31:26];
		o.ro   = s[25:20];
		o.imm  = {{21{s[31]}}, s[31:20]};
		o.uCmd = {s[1:0], s[19:16]};
		return o;
	endfunction

	// Fx chains by bit 10, predicated needs bit 11 and pwex
	function automatic logic wexOf(input logic [31:0] s, input logic wxe);
		return wxe && ((s[15:12] == 4'hF && s[10])
			|| (s[15:12] == 4'hE && s[11] && s[9]));
	endfunction

	function automatic regId_t evenOf(input regId_t r);
		return {r[0], r[4:1], 1'b0};
	endfunction

	function automatic expect_t expectOf(input logic [95:0] w, input logic wxe);
		expect_t     e;
		logic [31:0] s0;
		logic [31:0] s1;
		logic        scalar;
		s0     = w[31:0];
		s1     = w[63:32];
		e.a    = '{rn: RegZzr, rm: RegZzr, ro: RegZzr, imm: '0, uCmd: UCmdNop};
		e.b    = e.a;
		e.c    = e.a;
		scalar = 1'b0;
		if (s0[15:13] == 3'b111 && wexOf(s0, wxe) && wexOf(s1, wxe))
		begin
			e.form = FormWex3;
			e.a    = opOf(w[95:64]);
			e.b    = opOf(s1);
			e.c    = opOf(s0);
		end
		else if (s0[15:9] == 7'h7F)
		begin
			e.form = FormJumbo;
			e.a    = opOf(s1);
			// payload 8:0 over 31:16 of the prefix, then slot-1 bits 27:20
			e.a.imm = {s0[8:0], s0[31:16], s1[27:20]};
			scalar  = 1'b1;
		end
		else if (s0[15:13] == 3'b111 && wexOf(s0, wxe))
		begin
			e.form = FormWex2;
			e.a    = opOf(s1);
			e.b    = opOf(s0);
		end
		else
		begin
			e.form = FormScalar;
			e.a    = opOf(s0);
			scalar = 1'b1;
		end
		e.dual = (e.a.uCmd[5:4] == 2'b11);
		if (e.dual)
		begin
			if (!scalar)
				e.c = e.b;
			e.b    = e.a;
			e.a.rn = evenOf(e.b.rn);
			e.b.rn = evenOf(e.b.rn) | 6'd1;
			if (e.b.uCmd[3:1] != 3'b010)
			begin
				e.a.rm = evenOf(e.b.rm);
				e.b.rm = evenOf(e.b.rm) | 6'd1;
				e.a.ro = evenOf(e.b.ro);
				e.b.ro = evenOf(e.b.ro) | 6'd1;
			end
		end
		return e;
	endfunction

	task automatic noteFail(input string what);
		failCount++;
		$error("ERROR %0t: %s", $time, what);
	endtask

	assign expNow   = expectOf(istrWord, srWxe);
	assign lanesExp = {expNow.a, expNow.b, expNow.c};
	assign lanesNow = {laneA, laneB, laneC};

	assert property (@(posedge clock) outValid == (arstN && $past(inValid)))
		else noteFail("outValid is not inValid delayed by one cycle");

	// all three lanes idle right after reset
	assert property (@(posedge clock) $rose(arstN)
		|-> lanesNow == {3{RegZzr, RegZzr, RegZzr, 33'd0, UCmdNop}})
		else noteFail("lanes do not hold idle ops after reset");

	// lanes hold between strobes
	assert property (@(posedge clock) disable iff (!arstN)
		!$past(inValid) |-> lanesNow == $past(lanesNow))
		else noteFail("lanes changed while outValid was low");

	// with srWxe low the WEX words land here as well
	assert property (@(posedge clock) disable iff (!arstN)
		$past(inValid) && $past(expNow.form) == FormScalar && !$past(expNow.dual)
		|-> lanesNow == $past(lanesExp))
		else noteFail("scalar lanes differ from slot 0");

	assert property (@(posedge clock) disable iff (!arstN)
		$past(inValid) && !$past(expNow.dual)
		&& ($past(expNow.form) == FormWex2 || $past(expNow.form) == FormWex3)
		|-> lanesNow == $past(lanesExp))
		else noteFail("WEX lanes are not in reverse slot order");

	assert property (@(posedge clock) disable iff (!arstN)
		$past(inValid) && $past(expNow.form) == FormJumbo && !$past(expNow.dual)
		|-> lanesNow == $past(lanesExp))
		else noteFail("jumbo lane A has a wrong immediate or registers");

	assert property (@(posedge clock) disable iff (!arstN)
		$past(inValid) && $past(expNow.dual)
		|-> lanesNow == $past(lanesExp))
		else noteFail("dual-lane register pairs are wrong");

endmodule

// ==== wexDecodeTop.sv ====
`timescale 1ns/1ps

module wexDecodeTop (
	input  logic                            clock,
	input  logic                            arstN,
	input  logic                            inValid,
	input  logic [3*wexDecPkg::SlotW-1:0]   istrWord,
	input  logic                            srWxe,
	output logic                            outValid,
	output wexDecPkg::laneOp_t              laneA,
	output wexDecPkg::laneOp_t              laneB,
	output wexDecPkg::laneOp_t              laneC
);

	import wexDecPkg::*;

	slotInfo_t slotInfo [3];
	laneOp_t   steerA;
	laneOp_t   steerB;
	laneOp_t   steerC;
	logic      steerScalar;
	laneOp_t   pairA;
	laneOp_t   pairB;
	laneOp_t   pairC;

	// slot 0 is the low word of the fetch
	for (genvar i = 0; i < 3; i++)
	begin : genSlot
		opSlotDecoder slotDec (
			.slot  (istrWord[i*SlotW +: SlotW]),
			.srWxe (srWxe),
			.info  (slotInfo[i])
		);
	end

	bundleSteer steer (
		.s0       (slotInfo[0]),
		.s1       (slotInfo[1]),
		.s2       (slotInfo[2]),
		.laneA    (steerA),
		.laneB    (steerB),
		.laneC    (steerC),
		.isScalar (steerScalar)
	);

	dualLanePair pair (
		.laneAIn  (steerA),
		.laneBIn  (steerB),
		.laneCIn  (steerC),
		.isScalar (steerScalar),
		.laneA    (pairA),
		.laneB    (pairB),
		.laneC    (pairC)
	);

	// one-cycle decode register, lanes hold between strobes
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
			laneA    <= LaneIdle;
			laneB    <= LaneIdle;
			laneC    <= LaneIdle;
		end
		else
		begin
			outValid <= inValid;
			if (inValid)
			begin
				laneA <= pairA;
				laneB <= pairB;
				laneC <= pairC;
			end
		end
	end

endmodule

// ==== dualLanePair.sv ====
`timescale 1ns/1ps

module dualLanePair (
	input  wexDecPkg::laneOp_t laneAIn,
	input  wexDecPkg::laneOp_t laneBIn,
	input  wexDecPkg::laneOp_t laneCIn,
	input  logic               isScalar,
	output wexDecPkg::laneOp_t laneA,
	output wexDecPkg::laneOp_t laneB,
	output wexDecPkg::laneOp_t laneC
);

	import wexDecPkg::*;

	logic isDual;
	logic isMove;

	// even register of the 128-bit pair
	function automatic regId_t pairOf(input regId_t r);
		return {r[0], r[4:1], 1'b0};
	endfunction

	// odd half, bit 0 set
	function automatic regId_t pairHiOf(input regId_t r);
		regId_t p;
		p    = pairOf(r);
		p[0] = ~p[0];
		return p;
	endfunction

	assign isDual = (laneAIn.uCmd[5:4] == WxClass);

	// move class pairs only rn
	assign isMove = (laneAIn.uCmd[3:1] == 3'b010);

	always_comb
	begin
		laneA = laneAIn;
		laneB = laneBIn;
		laneC = laneCIn;

		if (isDual)
		begin
			// a WEX2 partner moves out to lane C
			if (!isScalar)
			begin
				laneC = laneBIn;
			end

			laneB = laneAIn;

			laneA.rn = pairOf(laneAIn.rn);
			laneB.rn = pairHiOf(laneAIn.rn);

			if (!isMove)
			begin
				laneA.rm = pairOf(laneAIn.rm);
				laneB.rm = pairHiOf(laneAIn.rm);
				laneA.ro = pairOf(laneAIn.ro);
				laneB.ro = pairHiOf(laneAIn.ro);
			end
		end
	end

endmodule

// ==== bundleSteer.sv ====
`timescale 1ns/1ps

module bundleSteer (
	input  wexDecPkg::slotInfo_t s0,
	input  wexDecPkg::slotInfo_t s1,
	input  wexDecPkg::slotInfo_t s2,
	output wexDecPkg::laneOp_t   laneA,
	output wexDecPkg::laneOp_t   laneB,
	output wexDecPkg::laneOp_t   laneC,
	output logic                 isScalar
);

	import wexDecPkg::*;

	logic    formWex3;
	logic    formJumbo;
	logic    formWex2;
	laneOp_t jumboOp;

	// bundle form, highest priority first
	always_comb
	begin
		formWex3  = 1'b0;
		formJumbo = 1'b0;
		formWex2  = 1'b0;
		if (s0.isFx && s0.isWex && s1.isWex)
		begin
			formWex3 = 1'b1;
		end
		else if (s0.isJumbo)
		begin
			formJumbo = 1'b1;
		end
		else if (s0.isFx && s0.isWex)
		begin
			formWex2 = 1'b1;
		end
	end

	// slot 1 with the immediate widened by the jumbo payload
	always_comb
	begin
		jumboOp = s1.op;

		// payload sign, payload bits 23:0, then slot-1 bits 27:20
		jumboOp.imm = {
			s0.jumboBits[JumboW-1],
			s0.jumboBits[JumboW-2:0],
			s1.op.imm[7:0]
		};
	end

	always_comb
	begin
		laneA    = LaneIdle;
		laneB    = LaneIdle;
		laneC    = LaneIdle;
		isScalar = 1'b0;

		if (formWex3)
		begin
			// three ops, reverse order
			laneA = s2.op;
			laneB = s1.op;
			laneC = s0.op;
		end
		else if (formJumbo)
		begin
			laneA    = jumboOp;
			isScalar = 1'b1;
		end
		else if (formWex2)
		begin
			laneA = s1.op;
			laneB = s0.op;
		end
		else
		begin
			// plain scalar op in slot 0
			laneA    = s0.op;
			isScalar = 1'b1;
		end
	end

endmodule

// ==== opSlotDecoder.sv ====
`timescale 1ns/1ps

module opSlotDecoder (
	input  wexDecPkg::slotWord_t slot,
	input  logic                 srWxe,
	output wexDecPkg::slotInfo_t info
);

	import wexDecPkg::*;

	logic [3:0] classPrefix;
	logic       isFx;
	logic       isPred;
	logic       wexFx;
	logic       wexPred;
	logic       isJumbo;

	// class prefix sits in the top four bits of the class field
	assign classPrefix = slot.op.opClass[5:2];

	always_comb
	begin
		isFx   = 1'b0;
		isPred = 1'b0;
		case (classPrefix)
			ClassPred:
			begin
				isFx   = 1'b1;
				isPred = 1'b1;
			end
			ClassFx:
			begin
				isFx = 1'b1;
			end
			default:
			begin
				isFx   = 1'b0;
				isPred = 1'b0;
			end
		endcase
	end

	// unconditional op chains by bit 10
	assign wexFx = isFx && !isPred && slot.op.opClass[0];

	// predicated op needs pwex and bit 11 together
	assign wexPred = isPred && slot.op.pwex && slot.op.opClass[1];

	assign isJumbo = (slot.jumbo.mark == JumboMark);

	always_comb
	begin
		info.isFx    = isFx;
		info.isPred  = isPred;
		info.isWex   = srWxe && (wexFx || wexPred);
		info.isJumbo = isJumbo;

		// payload high part goes above the low part
		info.jumboBits = {slot.jumbo.payHi, slot.jumbo.payLo};

		info.op.rn = slot.op.rn;
		info.op.rm = slot.op.rm;
		info.op.ro = slot.op.ro;

		// uCmd is opHi over opLo
		info.op.uCmd = {slot.op.opHi, slot.op.opLo};

		// sign extend slot bits 31:20
		info.op.imm = {
			{(ImmW - 2 * RegIdW){slot.op.rm[RegIdW-1]}},
			slot.op.rm,
			slot.op.ro
		};
	end

endmodule

// ==== wexDecPkg.sv ====
package wexDecPkg;

	// field widths
	localparam int RegIdW = 6;
	localparam int ImmW   = 33;
	localparam int UCmdW  = 6;
	localparam int SlotW  = 32;
	localparam int JumboW = 25;

	typedef logic [RegIdW-1:0] regId_t;

	// zero register, all ones
	localparam regId_t RegZzr = '1;

	// class prefixes in slot bits 15:12
	localparam logic [3:0] ClassPred = 4'b1110;
	localparam logic [3:0] ClassFx   = 4'b1111;

	// jumbo prefix mark in slot bits 15:9
	localparam logic [6:0] JumboMark = 7'b1111111;

	localparam logic [UCmdW-1:0] UCmdNop = '0;

	// uCmd bits 5:4 of a dual-lane op
	localparam logic [1:0] WxClass = 2'b11;

	// normal op layout of a slot
	typedef struct packed {
		regId_t     rm;
		regId_t     ro;
		logic [3:0] opLo;
		logic [5:0] opClass;
		logic       pwex;
		logic       spare;
		regId_t     rn;
		logic [1:0] opHi;
	} opView_t;

	// jumbo prefix layout of the same slot
	typedef struct packed {
		logic [15:0] payLo;
		logic [6:0]  mark;
		logic [8:0]  payHi;
	} jumboView_t;

	typedef union packed {
		opView_t    op;
		jumboView_t jumbo;
	} slotWord_t;

	// one decoded op as it leaves in a lane
	typedef struct packed {
		regId_t           rn;
		regId_t           rm;
		regId_t           ro;
		logic [ImmW-1:0]  imm;
		logic [UCmdW-1:0] uCmd;
	} laneOp_t;

	// per-slot decode result
	typedef struct packed {
		logic              isFx;
		logic              isPred;
		logic              isWex;
		logic              isJumbo;
		logic [JumboW-1:0] jumboBits;
		laneOp_t           op;
	} slotInfo_t;

	// what an unused lane holds
	localparam laneOp_t LaneIdle = '{
		rn:   RegZzr,
		rm:   RegZzr,
		ro:   RegZzr,
		imm:  '0,
		uCmd: UCmdNop
	};

endpackage
